//--- files.f
memMapPkg.sv
addrDecode.sv
strobeGen.sv
anticRegs.sv
pokeyRegs.sv
readMux.sv
memMapTop.sv
memMapTb.sv

//--- Bender.yml
package:
  name: mem_map

sources:
  - memMapPkg.sv
  - addrDecode.sv
  - strobeGen.sv
  - anticRegs.sv
  - pokeyRegs.sv
  - readMux.sv
  - memMapTop.sv
  - target: simulation
    files:
      - memMapTb.sv

//--- memMapTb.sv
// ####################
// Memory map testbench
// ####################
module memMapTb;

  localparam int StrobeWidth = 6;   // Still high when the mid-pulse rewrite lands
  localparam int WaitLimit   = 40;  // Cycles before a wait gives up

  logic                Fclk;
  logic                rst;
  memMapPkg::addrT     cpuAddr;
  logic                cpuWe;
  memMapPkg::byteT     cpuWrData, cpuRdData;
  logic                selRam, selCart, selBios, writeRam;
  memMapPkg::byteT     ramData, biosData, cartData;
  memMapPkg::anticUpdT anticUpd;
  memMapPkg::byteT     dlistLowIn, dlistHighIn, nmistIn, vcountIn;
  memMapPkg::byteT     penhIn, penvIn;
  memMapPkg::byteT     dmactl, chactl, hscrol, vscrol, pmbase, chbase;
  memMapPkg::byteT     wsync, nmien, dlistLow, dlistHigh, nmist, vcount;
  memMapPkg::byteT     kbcodeIn, randomIn, serinIn, irqstIn, skstatIn;
  memMapPkg::byteT     audf1, audc1, audf2, audc2, audf3, audc3, audf4, audc4;
  memMapPkg::byteT     audctl, skrest, serout, irqen, skctl;
  logic                potgoStrobe, stimerStrobe;

  logic [31:0] lfsrState = 32'h8a8f_79d2;  // Stimulus seed

  memMapTop #(.StrobeWidth(StrobeWidth)) i_dut (.*);  // Port names match one to one

  initial begin
    Fclk = 1'b0;
    forever #20 Fclk = ~Fclk;
  end

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
  function automatic logic [31:0] randBits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsrState = {lfsrState[30:0],
                   lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0]};
      v = {v[30:0], lfsrState[0]};
    end
    return v;
  endfunction

  task automatic checkByte(input memMapPkg::byteT got, input memMapPkg::byteT exp,
                           input string what);
    assert (got === exp) else begin
      $display("mismatch at %0t: %s read %02h, expected %02h", $time, what, got, exp);
      $display("Finished with errors");
      $fatal(1, "stopped at the first error");
    end
  endtask

  task automatic checkBit(input logic got, input logic exp, input string what);
    assert (got === exp) else begin
      $display("mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
      $display("Finished with errors");
      $fatal(1, "stopped at the first error");
    end
  endtask

  task automatic timeoutFail(input string what);
    $display("timeout at %0t: %s", $time, what);
    $display("Finished with errors");
    $fatal(1, "a wait ran out of cycles");
  endtask

  // ANTIC registers that hold a CPU write
  function automatic logic anticWritable(input logic [3:0] off);
    case (off)
      memMapPkg::OffVcount, memMapPkg::OffPenh, memMapPkg::OffPenv: return 1'b0;
      4'h6, 4'h8: return 1'b0;  // Holes
      default: return 1'b1;
    endcase
  endfunction

  function automatic memMapPkg::byteT anticReg(input logic [3:0] off);
    case (off)
      memMapPkg::OffDmactl: return dmactl;
      memMapPkg::OffChactl: return chactl;
      memMapPkg::OffDlistl: return dlistLow;
      memMapPkg::OffDlisth: return dlistHigh;
      memMapPkg::OffHscrol: return hscrol;
      memMapPkg::OffVscrol: return vscrol;
      memMapPkg::OffPmbase: return pmbase;
      memMapPkg::OffChbase: return chbase;
      memMapPkg::OffWsync:  return wsync;
      memMapPkg::OffVcount: return vcount;
      memMapPkg::OffNmien:  return nmien;
      memMapPkg::OffNmist:  return nmist;
      default:              return 8'hxx;
    endcase
  endfunction

  // POKEY registers that hold a CPU write, STIMER and POTGO only strobe
  function automatic logic pokeyWritable(input logic [3:0] off);
    case (off)
      memMapPkg::OffStimer, memMapPkg::OffPotgo, 4'hC: return 1'b0;
      default: return 1'b1;
    endcase
  endfunction

  function automatic memMapPkg::byteT pokeyReg(input logic [3:0] off);
    case (off)
      memMapPkg::OffAudf1:  return audf1;
      memMapPkg::OffAudc1:  return audc1;
      memMapPkg::OffAudf2:  return audf2;
      memMapPkg::OffAudc2:  return audc2;
      memMapPkg::OffAudf3:  return audf3;
      memMapPkg::OffAudc3:  return audc3;
      memMapPkg::OffAudf4:  return audf4;
      memMapPkg::OffAudc4:  return audc4;
      memMapPkg::OffAudctl: return audctl;
      memMapPkg::OffSkrest: return skrest;
      memMapPkg::OffSerout: return serout;
      memMapPkg::OffIrqen:  return irqen;
      memMapPkg::OffSkctl:  return skctl;
      default:              return 8'hxx;
    endcase
  endfunction

  function automatic logic strobeOf(input logic isPotgo);
    return isPotgo ? potgoStrobe : stimerStrobe;
  endfunction

  task automatic applyReset;
    @(negedge Fclk);
    rst = 1'b1;
    repeat (8) @(negedge Fclk);
    rst = 1'b0;
    #1;
  endtask

  // Write on one edge, then leave the address for a read back
  task automatic cpuWrite(input memMapPkg::addrT addr, input memMapPkg::byteT data);
    @(negedge Fclk);
    cpuAddr   = addr;
    cpuWrData = data;
    cpuWe     = 1'b1;
    @(negedge Fclk);
    cpuWe = 1'b0;
    #1;
  endtask

  task automatic checkResetState;
    for (int off = 0; off < 16; off++) begin
      if (anticWritable(4'(off)) || (4'(off) == memMapPkg::OffVcount))
        checkByte(anticReg(4'(off)), 8'h00, $sformatf("ANTIC reg %1h after reset", off));
      if (pokeyWritable(4'(off)))
        checkByte(pokeyReg(4'(off)), 8'h00, $sformatf("POKEY reg %1h after reset", off));
    end
    checkBit(potgoStrobe, 1'b0, "potgoStrobe after reset");
    checkBit(stimerStrobe, 1'b0, "stimerStrobe after reset");
  endtask

  task automatic testDecode;
    memMapPkg::addrT a;
    logic            we;
    logic            expRam;
    for (int n = 0; n < 300; n++) begin
      case (n)  // Region edges first
        0:       a = 16'h0000;
        1:       a = 16'h3FFF;
        2:       a = 16'h4000;
        3:       a = 16'hBFFF;
        4:       a = 16'hC000;
        5:       a = 16'hF7FF;
        6:       a = 16'hF800;
        7:       a = 16'hFFFF;
        default: a = 16'(randBits(16));
      endcase
      we = 1'(randBits(1));
      @(negedge Fclk);
      cpuAddr   = a;
      cpuWe     = we;
      cpuWrData = 8'(randBits(8));
      #1;
      expRam = a < 16'h4000;  // RAM below 4000
      checkBit(selRam, expRam, $sformatf("selRam at %04h", a));
      checkBit(selCart, (a >= 16'h4000) && (a <= 16'hBFFF),
               $sformatf("selCart at %04h", a));
      checkBit(selBios, a >= 16'hF800, $sformatf("selBios at %04h", a));
      checkBit(writeRam, we & expRam, $sformatf("writeRam at %04h", a));
    end
    @(negedge Fclk);
    cpuWe = 1'b0;
  endtask

  task automatic testAnticWrites;
    memMapPkg::byteT d;
    for (int off = 0; off < 16; off++) begin
      if (anticWritable(4'(off))) begin
        d = 8'(randBits(8));
        cpuWrite(memMapPkg::AnticBase | 16'(off), d);
        checkByte(anticReg(4'(off)), d, $sformatf("ANTIC reg %1h output", off));
        checkByte(cpuRdData, d, $sformatf("ANTIC reg %1h read back", off));
      end
    end
  endtask

  // VCOUNT lags vcountIn by one edge
  task automatic testVcount;
    memMapPkg::byteT prev;
    @(negedge Fclk);
    cpuAddr  = memMapPkg::AnticBase | memMapPkg::OffVcount;
    vcountIn = 8'(randBits(8));
    for (int n = 0; n < 10; n++) begin
      prev = vcountIn;
      @(negedge Fclk);
      vcountIn = 8'(randBits(8));
      #1;
      checkByte(cpuRdData, prev, "VCOUNT read");
      checkByte(vcount, prev, "vcount output");
    end
  endtask

  // One ANTIC update, optionally with a CPU write on the same edge
  task automatic anticUpdate(input int code, input logic cpuHit, input logic [3:0] cpuOff);
    memMapPkg::byteT oldLow, oldHigh, oldNmi;
    memMapPkg::byteT expLow, expHigh, expNmi;
    memMapPkg::byteT cpuData;
    oldLow  = 8'(randBits(8));
    oldHigh = 8'(randBits(8));
    oldNmi  = 8'(randBits(8));
    cpuData = 8'(randBits(8));
    cpuWrite(memMapPkg::AnticBase | memMapPkg::OffDlistl, oldLow);
    cpuWrite(memMapPkg::AnticBase | memMapPkg::OffDlisth, oldHigh);
    cpuWrite(memMapPkg::AnticBase | memMapPkg::OffNmist, oldNmi);
    // Fields per update code, new values are the inverse of the old ones
    expLow  = (code == 1 || code == 2 || code == 4 || code == 5) ? ~oldLow : oldLow;
    expHigh = (code == 2 || code == 5) ? ~oldHigh : oldHigh;
    expNmi  = (code == 4 || code == 5 || code == 6) ? ~oldNmi : oldNmi;
    if (cpuHit) begin
      case (cpuOff)  // CPU wins only on its own register
        memMapPkg::OffDlistl: expLow = cpuData;
        memMapPkg::OffDlisth: expHigh = cpuData;
        default:              expNmi = cpuData;
      endcase
    end
    @(negedge Fclk);
    anticUpd    = memMapPkg::anticUpdT'(code);
    dlistLowIn  = ~oldLow;
    dlistHighIn = ~oldHigh;
    nmistIn     = ~oldNmi;
    cpuAddr     = memMapPkg::AnticBase | cpuOff;
    cpuWrData   = cpuData;
    cpuWe       = cpuHit;
    @(negedge Fclk);
    anticUpd = memMapPkg::None;
    cpuWe    = 1'b0;
    #1;
    checkByte(dlistLow, expLow, $sformatf("dlistLow, code %0d cpu %b", code, cpuHit));
    checkByte(dlistHigh, expHigh, $sformatf("dlistHigh, code %0d cpu %b", code, cpuHit));
    checkByte(nmist, expNmi, $sformatf("nmist, code %0d cpu %b", code, cpuHit));
  endtask

  task automatic testAnticUpdates;
    for (int code = 0; code < 7; code++) begin
      anticUpdate(code, 1'b0, memMapPkg::OffDmactl);
      anticUpdate(code, 1'b1, memMapPkg::OffDlistl);
      anticUpdate(code, 1'b1, memMapPkg::OffDlisth);
      anticUpdate(code, 1'b1, memMapPkg::OffNmist);
    end
  endtask

  task automatic testPokeyWrites;
    memMapPkg::byteT d;
    for (int off = 0; off < 16; off++) begin
      if (pokeyWritable(4'(off))) begin
        d = 8'(randBits(8));
        cpuWrite(memMapPkg::PokeyBase | 16'(off), d);
        checkByte(pokeyReg(4'(off)), d, $sformatf("POKEY reg %1h output", off));
      end
    end
  endtask

  // Counts the high cycles that remain, bounded by WaitLimit
  task automatic countHigh(input logic isPotgo, output int cycles);
    cycles = 0;
    while (strobeOf(isPotgo)) begin
      cycles++;
      if (cycles > WaitLimit) timeoutFail("strobe stayed high");
      @(negedge Fclk);
    end
  endtask

  task automatic testStrobe(input logic isPotgo);
    memMapPkg::addrT a;
    int              cycles;
    a = memMapPkg::PokeyBase | (isPotgo ? memMapPkg::OffPotgo : memMapPkg::OffStimer);
    checkBit(strobeOf(isPotgo), 1'b0, $sformatf("strobe %b idle", isPotgo));
    cpuWrite(a, 8'(randBits(8)));
    countHigh(isPotgo, cycles);
    checkByte(8'(cycles), 8'(StrobeWidth), $sformatf("strobe %b width", isPotgo));
    // Rewrite three cycles into the pulse
    cpuWrite(a, 8'(randBits(8)));
    for (int n = 0; n < 3; n++) begin
      checkBit(strobeOf(isPotgo), 1'b1, $sformatf("strobe %b early pulse", isPotgo));
      @(negedge Fclk);
    end
    cpuWrite(a, 8'(randBits(8)));
    countHigh(isPotgo, cycles);
    checkByte(8'(cycles), 8'(StrobeWidth), $sformatf("strobe %b after rewrite", isPotgo));
  endtask

  task automatic checkRead(input memMapPkg::addrT a, input memMapPkg::byteT exp);
    @(negedge Fclk);
    cpuAddr = a;
    #1;
    checkByte(cpuRdData, exp, $sformatf("read at %04h", a));
  endtask

  task automatic testReadPath;
    memMapPkg::addrT a;
    memMapPkg::byteT d;
    for (int n = 0; n < 60; n++) begin
      @(negedge Fclk);
      ramData  = 8'(randBits(8));
      biosData = 8'(randBits(8));
      cartData = 8'(randBits(8));
      case (n % 3)
        0:       checkRead(16'(randBits(14)), ramData);
        1:       checkRead(16'h4000 + 16'(randBits(15)), cartData);
        default: checkRead(16'hF800 | 16'(randBits(11)), biosData);
      endcase
    end
    for (int off = 0; off < 16; off++) begin  // POKEY and pen inputs
      @(negedge Fclk);
      d = 8'(randBits(8));
      case (4'(off))
        memMapPkg::OffKbcode: kbcodeIn = d;
        memMapPkg::OffRandom: randomIn = d;
        memMapPkg::OffSerin:  serinIn  = d;
        memMapPkg::OffIrqst:  irqstIn  = d;
        memMapPkg::OffSkstat: skstatIn = d;
        default:              d = memMapPkg::UnmappedData;  // Paddle reads are gone
      endcase
      checkRead(memMapPkg::PokeyBase | 16'(off), d);
    end
    @(negedge Fclk);
    penhIn = 8'(randBits(8));
    penvIn = 8'(randBits(8));
    checkRead(memMapPkg::AnticBase | memMapPkg::OffPenh, penhIn);
    checkRead(memMapPkg::AnticBase | memMapPkg::OffPenv, penvIn);
    checkRead(16'hD406, 8'hFF);  // ANTIC holes
    checkRead(16'hD408, 8'hFF);
    checkRead(16'hD000, 8'hFF);  // GTIA
    checkRead(16'hD01F, 8'hFF);
    checkRead(16'hD200, 8'hFF);
    checkRead(16'hC000, 8'hFF);
    checkRead(16'hF7FF, 8'hFF);
    for (int n = 0; n < 40; n++) begin
      a = 16'hC000 + 16'(randBits(14));
      if ((a >= 16'hF800) || (a[15:4] == 12'hD40) || (a[15:4] == 12'hE80))
        a = {5'b11000, a[10:0]};  // Fold into C000-C7FF
      checkRead(a, 8'hFF);
    end
  endtask

  initial begin
    rst         = 1'b1;
    cpuAddr     = '0;
    cpuWe       = 1'b0;
    cpuWrData   = '0;
    ramData     = '0;
    biosData    = '0;
    cartData    = '0;
    anticUpd    = memMapPkg::None;
    dlistLowIn  = '0;
    dlistHighIn = '0;
    nmistIn     = '0;
    vcountIn    = 8'h5A;  // Nonzero while reset holds VCOUNT at 0
    penhIn      = '0;
    penvIn      = '0;
    kbcodeIn    = '0;
    randomIn    = '0;
    serinIn     = '0;
    irqstIn     = '0;
    skstatIn    = '0;
    repeat (8) @(negedge Fclk);
    rst = 1'b0;
    #1;
    checkResetState();
    testDecode();
    applyReset();  // Random writes above touched the banks
    checkResetState();
    testAnticWrites();
    testVcount();
    testAnticUpdates();
    testPokeyWrites();
    testStrobe(1'b1);
    testStrobe(1'b0);
    testReadPath();
    $display("Finished with no errors");
    $finish;
  end

endmodule

//--- memMapTop.sv
// ####################
// Memory map top
// ####################
module memMapTop #(
  parameter int StrobeWidth = 8  // POTGO and STIMER pulse length
) (
  input  logic                Fclk,
  input  logic                rst,
  input  memMapPkg::addrT     cpuAddr,
  input  logic                cpuWe,
  input  memMapPkg::byteT     cpuWrData,
  output memMapPkg::byteT     cpuRdData,
  // External memories
  output logic                selRam,
  output logic                selCart,
  output logic                selBios,
  output logic                writeRam,
  input  memMapPkg::byteT     ramData,
  input  memMapPkg::byteT     biosData,
  input  memMapPkg::byteT     cartData,
  // ANTIC side
  input  memMapPkg::anticUpdT anticUpd,
  input  memMapPkg::byteT     dlistLowIn,
  input  memMapPkg::byteT     dlistHighIn,
  input  memMapPkg::byteT     nmistIn,
  input  memMapPkg::byteT     vcountIn,
  input  memMapPkg::byteT     penhIn,
  input  memMapPkg::byteT     penvIn,
  output memMapPkg::byteT     dmactl,
  output memMapPkg::byteT     chactl,
  output memMapPkg::byteT     hscrol,
  output memMapPkg::byteT     vscrol,
  output memMapPkg::byteT     pmbase,
  output memMapPkg::byteT     chbase,
  output memMapPkg::byteT     wsync,
  output memMapPkg::byteT     nmien,
  output memMapPkg::byteT     dlistLow,
  output memMapPkg::byteT     dlistHigh,
  output memMapPkg::byteT     nmist,
  output memMapPkg::byteT     vcount,
  // POKEY side
  input  memMapPkg::byteT     kbcodeIn,
  input  memMapPkg::byteT     randomIn,
  input  memMapPkg::byteT     serinIn,
  input  memMapPkg::byteT     irqstIn,
  input  memMapPkg::byteT     skstatIn,
  output memMapPkg::byteT     audf1,
  output memMapPkg::byteT     audc1,
  output memMapPkg::byteT     audf2,
  output memMapPkg::byteT     audc2,
  output memMapPkg::byteT     audf3,
  output memMapPkg::byteT     audc3,
  output memMapPkg::byteT     audf4,
  output memMapPkg::byteT     audc4,
  output memMapPkg::byteT     audctl,
  output memMapPkg::byteT     skrest,
  output memMapPkg::byteT     serout,
  output memMapPkg::byteT     irqen,
  output memMapPkg::byteT     skctl,
  output logic                potgoStrobe,
  output logic                stimerStrobe
);

  logic writeReg;  // CPU write outside the memories

  addrDecode decodeStage (
    .cpuAddr (cpuAddr),
    .cpuWe   (cpuWe),
    .selRam  (selRam),
    .selCart (selCart),
    .selBios (selBios),
    .writeRam(writeRam),
    .writeReg(writeReg)
  );

  anticRegs anticBank (
    .Fclk       (Fclk),
    .rst        (rst),
    .writeReg   (writeReg),
    .cpuAddr    (cpuAddr),
    .cpuWrData  (cpuWrData),
    .anticUpd   (anticUpd),
    .dlistLowIn (dlistLowIn),
    .dlistHighIn(dlistHighIn),
    .nmistIn    (nmistIn),
    .vcountIn   (vcountIn),
    .dmactl     (dmactl),
    .chactl     (chactl),
    .hscrol     (hscrol),
    .vscrol     (vscrol),
    .pmbase     (pmbase),
    .chbase     (chbase),
    .wsync      (wsync),
    .nmien      (nmien),
    .dlistLow   (dlistLow),
    .dlistHigh  (dlistHigh),
    .nmist      (nmist),
    .vcount     (vcount)
  );

  pokeyRegs #(.StrobeWidth(StrobeWidth)) pokeyBank (
    .Fclk        (Fclk),
    .rst         (rst),
    .writeReg    (writeReg),
    .cpuAddr     (cpuAddr),
    .cpuWrData   (cpuWrData),
    .audf1       (audf1),
    .audc1       (audc1),
    .audf2       (audf2),
    .audc2       (audc2),
    .audf3       (audf3),
    .audc3       (audc3),
    .audf4       (audf4),
    .audc4       (audc4),
    .audctl      (audctl),
    .skrest      (skrest),
    .serout      (serout),
    .irqen       (irqen),
    .skctl       (skctl),
    .potgoStrobe (potgoStrobe),
    .stimerStrobe(stimerStrobe)
  );

  readMux resultMux (
    .cpuAddr  (cpuAddr),
    .selRam   (selRam),
    .selCart  (selCart),
    .selBios  (selBios),
    .ramData  (ramData),
    .biosData (biosData),
    .cartData (cartData),
    .dmactl   (dmactl),
    .chactl   (chactl),
    .dlistLow (dlistLow),
    .dlistHigh(dlistHigh),
    .hscrol   (hscrol),
    .vscrol   (vscrol),
    .pmbase   (pmbase),
    .chbase   (chbase),
    .wsync    (wsync),
    .vcount   (vcount),
    .nmien    (nmien),
    .nmist    (nmist),
    .penhIn   (penhIn),
    .penvIn   (penvIn),
    .kbcodeIn (kbcodeIn),
    .randomIn (randomIn),
    .serinIn  (serinIn),
    .irqstIn  (irqstIn),
    .skstatIn (skstatIn),
    .cpuRdData(cpuRdData)
  );

endmodule

//--- readMux.sv
// ####################
// CPU read mux
// ####################
module readMux (
  input  memMapPkg::addrT cpuAddr,
  input  logic            selRam,
  input  logic            selCart,
  input  logic            selBios,
  input  memMapPkg::byteT ramData,
  input  memMapPkg::byteT biosData,
  input  memMapPkg::byteT cartData,
  input  memMapPkg::byteT dmactl,
  input  memMapPkg::byteT chactl,
  input  memMapPkg::byteT dlistLow,
  input  memMapPkg::byteT dlistHigh,
  input  memMapPkg::byteT hscrol,
  input  memMapPkg::byteT vscrol,
  input  memMapPkg::byteT pmbase,
  input  memMapPkg::byteT chbase,
  input  memMapPkg::byteT wsync,
  input  memMapPkg::byteT vcount,
  input  memMapPkg::byteT nmien,
  input  memMapPkg::byteT nmist,
  input  memMapPkg::byteT penhIn,
  input  memMapPkg::byteT penvIn,
  input  memMapPkg::byteT kbcodeIn,
  input  memMapPkg::byteT randomIn,
  input  memMapPkg::byteT serinIn,
  input  memMapPkg::byteT irqstIn,
  input  memMapPkg::byteT skstatIn,
  output memMapPkg::byteT cpuRdData
);

  logic            anticHit;
  logic            pokeyHit;
  logic [3:0]      regOff;
  memMapPkg::byteT anticData;  // ANTIC bank at this offset
  memMapPkg::byteT pokeyData;  // POKEY read inputs at this offset

  assign regOff   = cpuAddr[3:0];
  assign anticHit = cpuAddr[15:4] == memMapPkg::AnticBase[15:4];
  assign pokeyHit = cpuAddr[15:4] == memMapPkg::PokeyBase[15:4];

  always_comb begin
    case (regOff)
      memMapPkg::OffDmactl: anticData = dmactl;
      memMapPkg::OffChactl: anticData = chactl;
      memMapPkg::OffDlistl: anticData = dlistLow;
      memMapPkg::OffDlisth: anticData = dlistHigh;
      memMapPkg::OffHscrol: anticData = hscrol;
      memMapPkg::OffVscrol: anticData = vscrol;
      memMapPkg::OffPmbase: anticData = pmbase;
      memMapPkg::OffChbase: anticData = chbase;
      memMapPkg::OffWsync:  anticData = wsync;
      memMapPkg::OffVcount: anticData = vcount;  // One cycle behind vcountIn
      memMapPkg::OffPenh:   anticData = penhIn;
      memMapPkg::OffPenv:   anticData = penvIn;
      memMapPkg::OffNmien:  anticData = nmien;
      memMapPkg::OffNmist:  anticData = nmist;
      default:              anticData = memMapPkg::UnmappedData;  // 6 and 8
    endcase
  end

  // Paddle offsets 0-8 are gone, so most of the low half reads as a hole
  always_comb begin
    case (regOff)
      memMapPkg::OffKbcode: pokeyData = kbcodeIn;
      memMapPkg::OffRandom: pokeyData = randomIn;
      memMapPkg::OffSerin:  pokeyData = serinIn;
      memMapPkg::OffIrqst:  pokeyData = irqstIn;
      memMapPkg::OffSkstat: pokeyData = skstatIn;
      default:              pokeyData = memMapPkg::UnmappedData;
    endcase
  end

  // Memories first, then the two banks, anything else is a hole
  assign cpuRdData = selRam   ? ramData   :
                     selBios  ? biosData  :
                     selCart  ? cartData  :
                     anticHit ? anticData :
                     pokeyHit ? pokeyData :
                     memMapPkg::UnmappedData;

endmodule

//--- pokeyRegs.sv
// ####################
// POKEY write registers
// ####################
module pokeyRegs #(
  parameter int StrobeWidth = 8
) (
  input  logic            Fclk,
  input  logic            rst,
  input  logic            writeReg,
  input  memMapPkg::addrT cpuAddr,
  input  memMapPkg::byteT cpuWrData,
  output memMapPkg::byteT audf1,
  output memMapPkg::byteT audc1,
  output memMapPkg::byteT audf2,
  output memMapPkg::byteT audc2,
  output memMapPkg::byteT audf3,
  output memMapPkg::byteT audc3,
  output memMapPkg::byteT audf4,
  output memMapPkg::byteT audc4,
  output memMapPkg::byteT audctl,
  output memMapPkg::byteT skrest,
  output memMapPkg::byteT serout,
  output memMapPkg::byteT irqen,
  output memMapPkg::byteT skctl,
  output logic            potgoStrobe,
  output logic            stimerStrobe
);

  logic       bankWrite;  // CPU write lands in E800-E80F
  logic [3:0] regOff;

  assign regOff    = cpuAddr[3:0];
  assign bankWrite = writeReg && (cpuAddr[15:4] == memMapPkg::PokeyBase[15:4]);

  always_ff @(posedge Fclk or posedge rst) begin
    if (rst) begin
      audf1  <= '0;
      audc1  <= '0;
      audf2  <= '0;
      audc2  <= '0;
      audf3  <= '0;
      audc3  <= '0;
      audf4  <= '0;
      audc4  <= '0;
      audctl <= '0;
      skrest <= '0;
      serout <= '0;
      irqen  <= '0;
      skctl  <= '0;
    end else if (bankWrite) begin
      case (regOff)
        memMapPkg::OffAudf1:  audf1  <= cpuWrData;
        memMapPkg::OffAudc1:  audc1  <= cpuWrData;
        memMapPkg::OffAudf2:  audf2  <= cpuWrData;
        memMapPkg::OffAudc2:  audc2  <= cpuWrData;
        memMapPkg::OffAudf3:  audf3  <= cpuWrData;
        memMapPkg::OffAudc3:  audc3  <= cpuWrData;
        memMapPkg::OffAudf4:  audf4  <= cpuWrData;
        memMapPkg::OffAudc4:  audc4  <= cpuWrData;
        memMapPkg::OffAudctl: audctl <= cpuWrData;
        memMapPkg::OffSkrest: skrest <= cpuWrData;
        memMapPkg::OffSerout: serout <= cpuWrData;
        memMapPkg::OffIrqen:  irqen  <= cpuWrData;
        memMapPkg::OffSkctl:  skctl  <= cpuWrData;
        default: ;  // STIMER, POTGO and hole at C
      endcase
    end
  end

  // The data of these two writes is ignored, only the hit matters
  strobeGen #(.StrobeWidth(StrobeWidth)) potgoGen (
    .Fclk   (Fclk),
    .rst    (rst),
    .trigger(bankWrite && (regOff == memMapPkg::OffPotgo)),
    .strobe (potgoStrobe)
  );

  strobeGen #(.StrobeWidth(StrobeWidth)) stimerGen (
    .Fclk   (Fclk),
    .rst    (rst),
    .trigger(bankWrite && (regOff == memMapPkg::OffStimer)),
    .strobe (stimerStrobe)
  );

endmodule

//--- anticRegs.sv
// ####################
// ANTIC register bank
// ####################
module anticRegs (
  input  logic                Fclk,
  input  logic                rst,
  input  logic                writeReg,
  input  memMapPkg::addrT     cpuAddr,
  input  memMapPkg::byteT     cpuWrData,
  input  memMapPkg::anticUpdT anticUpd,
  input  memMapPkg::byteT     dlistLowIn,
  input  memMapPkg::byteT     dlistHighIn,
  input  memMapPkg::byteT     nmistIn,
  input  memMapPkg::byteT     vcountIn,
  output memMapPkg::byteT     dmactl,
  output memMapPkg::byteT     chactl,
  output memMapPkg::byteT     hscrol,
  output memMapPkg::byteT     vscrol,
  output memMapPkg::byteT     pmbase,
  output memMapPkg::byteT     chbase,
  output memMapPkg::byteT     wsync,
  output memMapPkg::byteT     nmien,
  output memMapPkg::byteT     dlistLow,
  output memMapPkg::byteT     dlistHigh,
  output memMapPkg::byteT     nmist,
  output memMapPkg::byteT     vcount
);

  logic       bankWrite;  // CPU write lands in D400-D40F
  logic [3:0] regOff;
  logic       updLow;     // ANTIC loads DLISTL
  logic       updHigh;    // ANTIC loads DLISTH
  logic       updNmi;     // ANTIC loads NMIST

  assign regOff    = cpuAddr[3:0];
  assign bankWrite = writeReg && (cpuAddr[15:4] == memMapPkg::AnticBase[15:4]);

  // Which fields the ANTIC update carries
  always_comb begin
    updLow  = 1'b0;
    updHigh = 1'b0;
    updNmi  = 1'b0;
    case (anticUpd)
      memMapPkg::DlistLow: updLow = 1'b1;
      memMapPkg::DlistBoth: begin
        updLow  = 1'b1;
        updHigh = 1'b1;
      end
      memMapPkg::DlistLowNmi: begin
        updLow = 1'b1;
        updNmi = 1'b1;
      end
      memMapPkg::DlistBothNmi: begin
        updLow  = 1'b1;
        updHigh = 1'b1;
        updNmi  = 1'b1;
      end
      memMapPkg::NmiOnly: updNmi = 1'b1;
      default: ;  // None and Reserved leave the bank alone
    endcase
  end

  always_ff @(posedge Fclk or posedge rst) begin
    if (rst) begin
      dmactl    <= '0;
      chactl    <= '0;
      hscrol    <= '0;
      vscrol    <= '0;
      pmbase    <= '0;
      chbase    <= '0;
      wsync     <= '0;
      nmien     <= '0;
      dlistLow  <= '0;
      dlistHigh <= '0;
      nmist     <= '0;
      vcount    <= '0;
    end else begin
      vcount <= vcountIn;  // Free running sample

      // ANTIC side first
      if (updLow)  dlistLow  <= dlistLowIn;
      if (updHigh) dlistHigh <= dlistHighIn;
      if (updNmi)  nmist     <= nmistIn;

      // CPU write comes last so it overrides only the register it hits
      if (bankWrite) begin
        case (regOff)
          memMapPkg::OffDmactl: dmactl    <= cpuWrData;
          memMapPkg::OffChactl: chactl    <= cpuWrData;
          memMapPkg::OffDlistl: dlistLow  <= cpuWrData;
          memMapPkg::OffDlisth: dlistHigh <= cpuWrData;
          memMapPkg::OffHscrol: hscrol    <= cpuWrData;
          memMapPkg::OffVscrol: vscrol    <= cpuWrData;
          memMapPkg::OffPmbase: pmbase    <= cpuWrData;
          memMapPkg::OffChbase: chbase    <= cpuWrData;
          memMapPkg::OffWsync:  wsync     <= cpuWrData;
          memMapPkg::OffNmien:  nmien     <= cpuWrData;
          memMapPkg::OffNmist:  nmist     <= cpuWrData;  // NMIRES
          default: ;  // VCOUNT, PENH, PENV and holes
        endcase
      end
    end
  end

endmodule

//--- strobeGen.sv
// ####################
// Strobe stretcher
// ####################
module strobeGen #(
  parameter int StrobeWidth = 8  // Cycles the strobe stays high
) (
  input  logic Fclk,
  input  logic rst,
  input  logic trigger,
  output logic strobe
);

  localparam int CntW = $clog2(StrobeWidth + 1);

  logic [CntW-1:0] cnt;  // Cycles left in the pulse

  always_ff @(posedge Fclk or posedge rst) begin
    if (rst) begin
      cnt <= '0;
    end else if (trigger) begin
      cnt <= CntW'(StrobeWidth);  // Load or restart
    end else if (cnt != '0) begin
      cnt <= cnt - 1'b1;
    end
  end

  // High from the trigger edge for StrobeWidth cycles
  assign strobe = cnt != '0;

endmodule

//--- addrDecode.sv
// ####################
// Address decode
// ####################
module addrDecode (
  input  memMapPkg::addrT cpuAddr,
  input  logic            cpuWe,
  output logic            selRam,
  output logic            selCart,
  output logic            selBios,
  output logic            writeRam,
  output logic            writeReg
);

  logic inMemory;  // Any of the three memory regions

  // Region classification, unsigned compares
  assign selRam  = cpuAddr < memMapPkg::RamTop;
  assign selCart = (cpuAddr >= memMapPkg::RamTop) && (cpuAddr < memMapPkg::CartTop);
  assign selBios = cpuAddr >= memMapPkg::BiosBase;

  // C000 to F7FF falls through to the register region
  assign inMemory = selRam | selCart | selBios;

  // Write steering
  assign writeRam = cpuWe & selRam;
  assign writeReg = cpuWe & ~inMemory;  // BIOS and cart writes are dropped

endmodule

//--- memMapPkg.sv
// ####################
// Memory map types
// ####################
package memMapPkg;

  typedef logic [7:0]  byteT;  // CPU data bus and register width
  typedef logic [15:0] addrT;  // CPU address

  // Region bounds
  localparam addrT RamTop   = 16'h4000;  // First address past RAM
  localparam addrT CartTop  = 16'hC000;  // First address past cartridge
  localparam addrT BiosBase = 16'hF800;  // BIOS runs to FFFF

  // Register banks, offset in the low nibble
  localparam addrT AnticBase = 16'hD400;
  localparam addrT PokeyBase = 16'hE800;

  // ANTIC offsets
  localparam logic [3:0] OffDmactl = 4'h0;
  localparam logic [3:0] OffChactl = 4'h1;
  localparam logic [3:0] OffDlistl = 4'h2;
  localparam logic [3:0] OffDlisth = 4'h3;
  localparam logic [3:0] OffHscrol = 4'h4;
  localparam logic [3:0] OffVscrol = 4'h5;
  localparam logic [3:0] OffPmbase = 4'h7;
  localparam logic [3:0] OffChbase = 4'h9;
  localparam logic [3:0] OffWsync  = 4'hA;
  localparam logic [3:0] OffVcount = 4'hB;  // Read only
  localparam logic [3:0] OffPenh   = 4'hC;  // Read only
  localparam logic [3:0] OffPenv   = 4'hD;  // Read only
  localparam logic [3:0] OffNmien  = 4'hE;
  localparam logic [3:0] OffNmist  = 4'hF;  // NMIRES on write

  // POKEY write offsets
  localparam logic [3:0] OffAudf1  = 4'h0;
  localparam logic [3:0] OffAudc1  = 4'h1;
  localparam logic [3:0] OffAudf2  = 4'h2;
  localparam logic [3:0] OffAudc2  = 4'h3;
  localparam logic [3:0] OffAudf3  = 4'h4;
  localparam logic [3:0] OffAudc3  = 4'h5;
  localparam logic [3:0] OffAudf4  = 4'h6;
  localparam logic [3:0] OffAudc4  = 4'h7;
  localparam logic [3:0] OffAudctl = 4'h8;
  localparam logic [3:0] OffStimer = 4'h9;  // Strobe only
  localparam logic [3:0] OffSkrest = 4'hA;
  localparam logic [3:0] OffPotgo  = 4'hB;  // Strobe only
  localparam logic [3:0] OffSerout = 4'hD;
  localparam logic [3:0] OffIrqen  = 4'hE;
  localparam logic [3:0] OffSkctl  = 4'hF;

  // POKEY read offsets, shared with the write side
  localparam logic [3:0] OffKbcode = 4'h9;
  localparam logic [3:0] OffRandom = 4'hA;
  localparam logic [3:0] OffSerin  = 4'hD;
  localparam logic [3:0] OffIrqst  = 4'hE;
  localparam logic [3:0] OffSkstat = 4'hF;

  localparam byteT UnmappedData = 8'hFF;  // Read of a hole

  // ANTIC's own register update code
  typedef enum logic [2:0] {
    None         = 3'd0,
    DlistLow     = 3'd1,
    DlistBoth    = 3'd2,
    Reserved     = 3'd3,  // No effect
    DlistLowNmi  = 3'd4,
    DlistBothNmi = 3'd5,
    NmiOnly      = 3'd6
  } anticUpdT;

endpackage
